/* cast.f */
+incdir+test
hw/cast_pkg.sv
hw/cast_pipe_reg.sv
hw/cast_decode.sv
hw/cast_shift.sv
hw/cast_round.sv
hw/cast_unit.sv
test/cast_unit_tb.sv

/* test/cast_vectors.svh */
task automatic load_vectors();
  // op, op_mod, rnd_mode, operand, expected result, expected status {nv,dz,of,uf,nx}
  add_row(I2F, 1'b0, RNE, 32'h00000000, 32'h00000000, ST_OK);  // Zero gives +0
  add_row(I2F, 1'b0, RNE, 32'h00000001, 32'h3F800000, ST_OK);
  add_row(I2F, 1'b0, RDN, 32'hFFFFFFFF, 32'hBF800000, ST_OK);  // -1
  add_row(I2F, 1'b0, RNE, 32'h80000000, 32'hCF000000, ST_OK);  // -2^31
  add_row(I2F, 1'b1, RNE, 32'h80000000, 32'h4F000000, ST_OK);  // 2^31 unsigned
  add_row(I2F, 1'b1, RNE, 32'hFFFFFFFF, 32'h4F800000, ST_NX);  // Rounds up to 2^32
  add_row(I2F, 1'b1, RTZ, 32'hFFFFFFFF, 32'h4F7FFFFF, ST_NX);
  add_row(I2F, 1'b0, RNE, 32'h7FFFFFFF, 32'h4F000000, ST_NX);
  // 2^24+1 is a tie between two floats
  add_row(I2F, 1'b0, RNE, 32'h01000001, 32'h4B800000, ST_NX);
  add_row(I2F, 1'b0, RUP, 32'h01000001, 32'h4B800001, ST_NX);
  add_row(I2F, 1'b0, RMM, 32'h01000001, 32'h4B800001, ST_NX);
  add_row(I2F, 1'b0, RDN, 32'hFEFFFFFF, 32'hCB800001, ST_NX);  // -(2^24+1)
  add_row(I2F, 1'b0, RMM, 32'hFEFFFFFF, 32'hCB800001, ST_NX);
  add_row(I2F, 1'b0, RNE, 32'h02000003, 32'h4C000001, ST_NX);  // Above half ulp
  add_row(I2F, 1'b1, RUP, 32'h02000001, 32'h4C000001, ST_NX);  // Below half ulp
  // Float to integer
  add_row(F2I, 1'b0, RNE, 32'h42F60000, 32'h0000007B, ST_OK);  // 123.0
  add_row(F2I, 1'b0, RNE, 32'h3FC00000, 32'h00000002, ST_NX);  // 1.5
  add_row(F2I, 1'b0, RTZ, 32'h3FC00000, 32'h00000001, ST_NX);
  add_row(F2I, 1'b0, RMM, 32'h40200000, 32'h00000003, ST_NX);  // 2.5
  add_row(F2I, 1'b0, RDN, 32'hBFC00000, 32'hFFFFFFFE, ST_NX);  // -1.5
  add_row(F2I, 1'b0, RNE, 32'h3F000000, 32'h00000000, ST_NX);  // 0.5 tie to even
  add_row(F2I, 1'b0, RUP, 32'h3E99999A, 32'h00000001, ST_NX);  // 0.3
  add_row(F2I, 1'b0, RDN, 32'hBE99999A, 32'hFFFFFFFF, ST_NX);  // -0.3
  add_row(F2I, 1'b0, RUP, 32'h00000001, 32'h00000001, ST_NX);  // Smallest subnormal
  add_row(F2I, 1'b0, RNE, 32'hCF000000, 32'h80000000, ST_OK);  // Exactly -2^31
  add_row(F2I, 1'b1, RNE, 32'h4F32D05E, 32'hB2D05E00, ST_OK);  // 3e9 unsigned
  // Special cases
  add_row(F2I, 1'b0, RNE, 32'h4F32D05E, 32'h7FFFFFFF, ST_NV);  // 3e9 too big for signed
  add_row(F2I, 1'b0, RNE, 32'h7FC00000, 32'h7FFFFFFF, ST_NV);  // NaN
  add_row(F2I, 1'b1, RNE, 32'h7FC00000, 32'hFFFFFFFF, ST_NV);
  add_row(F2I, 1'b0, RNE, 32'hFF800000, 32'h80000000, ST_NV);  // -inf
  add_row(F2I, 1'b1, RTZ, 32'h7F800000, 32'hFFFFFFFF, ST_NV);  // +inf
  add_row(F2I, 1'b1, RNE, 32'h4F800000, 32'hFFFFFFFF, ST_NV);  // 2^32
  add_row(F2I, 1'b0, RTZ, 32'hCF800000, 32'h80000000, ST_NV);  // -2^32
  add_row(F2I, 1'b1, RNE, 32'hBF800000, 32'h00000000, ST_NV);  // -1.0 unsigned
  add_row(F2I, 1'b1, RNE, 32'hBE99999A, 32'h00000000, ST_NX);  // Rounds to zero
  add_row(F2I, 1'b1, RDN, 32'hBE99999A, 32'h00000000, ST_NV);  // Rounds to -1
endtask

/* test/cast_unit_tb.sv */
module cast_unit_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import cast_pkg::*;

  localparam int         CLK_PERIOD = 20;
  localparam logic [4:0] ST_OK = 5'b00000;
  localparam logic [4:0] ST_NX = 5'b00001;  // Inexact alone
  localparam logic [4:0] ST_NV = 5'b10000;  // Invalid alone

  typedef struct packed {
    cast_op_e    op;
    logic        op_mod;
    round_mode_e rnd_mode;
    logic [31:0] operand;
    logic [31:0] exp_result;
    logic [4:0]  exp_status;
  } row_t;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  cast_req_t req_i;
  logic      in_valid_i;
  logic      in_ready_o;
  cast_rsp_t rsp_o;
  logic      out_valid_o;
  logic      out_ready_i;
  logic      flush_i;
  logic      busy_o;

  row_t vectors[$];

  cast_unit UUT (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_i       ( req_i       ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .rsp_o       ( rsp_o       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .flush_i     ( flush_i     ),
    .busy_o      ( busy_o      )
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  task automatic add_row(input cast_op_e op, input logic op_mod, input round_mode_e rm,
                         input logic [31:0] operand, input logic [31:0] result,
                         input logic [4:0] status);
    row_t row;
    row = '{op, op_mod, rm, operand, result, status};
    vectors.push_back(row);
  endtask

  `include "cast_vectors.svh"

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  function automatic cast_req_t make_req(input int idx);
    cast_req_t req;
    req.op       = vectors[idx].op;
    req.op_mod   = vectors[idx].op_mod;
    req.rnd_mode = vectors[idx].rnd_mode;
    req.operand  = vectors[idx].operand;
    req.tag      = TAG_WIDTH'(idx % 16);  // Row index wraps on 4 bits
    return req;
  endfunction

  // Compares the response on the port against row idx
  task automatic check_row(input int idx);
    check_equal($sformatf("rsp_o.result row %0d", idx), rsp_o.result,
                vectors[idx].exp_result);
    check_equal($sformatf("rsp_o.status row %0d", idx), rsp_o.status,
                vectors[idx].exp_status);
    check_equal($sformatf("rsp_o.tag row %0d", idx), rsp_o.tag, idx % 16);
  endtask

  // ----------------------------------------------------------------------
  // Driver and monitor, handshakes seen at the falling edge
  // ----------------------------------------------------------------------
  task automatic drive_rows(input int first, input int last);
    int idx;
    idx = first;
    while (idx < last) begin
      @(posedge clk_i);
      if ($urandom % 4 == 0) begin
        in_valid_i <= 1'b0;  // Input gap
      end else begin
        in_valid_i <= 1'b1;
        req_i      <= make_req(idx);
        @(negedge clk_i);
        while (!in_ready_o) begin
          @(negedge clk_i);  // Hold item under back-pressure
        end
        idx++;
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
  endtask

  task automatic collect_rows(input int first, input int last);
    int idx;
    idx = first;
    while (idx < last) begin
      @(posedge clk_i);
      out_ready_i <= ($urandom % 3 != 0);  // Random stalls
      @(negedge clk_i);
      if (out_valid_o && out_ready_i) begin
        check_row(idx);
        idx++;
      end
    end
    @(posedge clk_i);
    out_ready_i <= 1'b1;
  endtask

  task automatic watchdog(input int limit_ns);
    #(limit_ns);
    $display("timeout, responses missing");
    $display("TB FAILED");
    $fatal(1);
  endtask

  initial begin
    int edges;
    int seed;
    rst_n_i     = 1'b0;
    req_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    flush_i     = 1'b0;
    seed        = $urandom(57527);  // Single seed for the whole run
    load_vectors();
    fork
      watchdog(20 * vectors.size() * CLK_PERIOD);
    join_none

    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_equal("out_valid_o after reset", out_valid_o, 0);
    check_equal("busy_o after reset", busy_o, 0);
    check_equal("in_ready_o after reset", in_ready_o, 1);

    // Single item latency, accept edge counts as the first
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    in_valid_i  <= 1'b1;
    req_i       <= make_req(1);
    @(negedge clk_i);
    check_equal("in_ready_o", in_ready_o, 1);
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
      if (edges == 1) in_valid_i <= 1'b0;
      @(negedge clk_i);
    end while (!out_valid_o && edges < 8);
    check_equal("latency in edges", edges, 3);
    check_row(1);

    // Full table with gaps and stalls
    fork
      drive_rows(0, vectors.size());
      collect_rows(0, vectors.size());
    join
    @(negedge clk_i);
    check_equal("busy_o after drain", busy_o, 0);

    // ----------------------------------------------------------------------
    // Flush with three items in flight
    // ----------------------------------------------------------------------
    for (int k = 0; k < 3; k++) begin
      @(posedge clk_i);
      out_ready_i <= 1'b0;
      in_valid_i  <= 1'b1;
      req_i       <= make_req(10 + k);
      @(negedge clk_i);
      check_equal("in_ready_o while filling", in_ready_o, 1);
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;
    @(negedge clk_i);
    check_equal("in_ready_o when full", in_ready_o, 0);
    check_equal("busy_o when full", busy_o, 1);
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i     <= 1'b0;
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    check_equal("busy_o after flush", busy_o, 0);
    repeat (4) begin
      @(negedge clk_i);
      check_equal("out_valid_o after flush", out_valid_o, 0);  // Flushed items gone
    end
    fork
      drive_rows(0, 6);
      collect_rows(0, 6);
    join

    $display("TB PASSED");
    $finish;
  end

endmodule

/* hw/cast_unit.sv */
module cast_unit (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Request side
  input  cast_pkg::cast_req_t req_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  // Response side
  output cast_pkg::cast_rsp_t rsp_o,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  // Control
  input  logic                flush_i,
  output logic                busy_o
);
  import cast_pkg::*;

  norm_t     norm_d, norm_q;
  shifted_t  shift_d, shift_q;
  cast_rsp_t rsp_d;

  logic norm_valid, norm_ready;    // Register 1 to stage 2
  logic shift_valid, shift_ready;  // Register 2 to stage 3

  // ----------------------------------------------------------------------
  // Stage 1 decode and normalize
  // ----------------------------------------------------------------------
  cast_decode i_decode (
    .req_i  ( req_i  ),
    .norm_o ( norm_d )
  );

  cast_pipe_reg #(
    .payload_t ( norm_t )
  ) i_reg_norm (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .flush_i   ( flush_i    ),
    .valid_i   ( in_valid_i ),
    .payload_i ( norm_d     ),
    .ready_o   ( in_ready_o ),
    .ready_i   ( norm_ready ),
    .valid_o   ( norm_valid ),
    .payload_o ( norm_q     )
  );

  // ----------------------------------------------------------------------
  // Stage 2 range check and alignment
  // ----------------------------------------------------------------------
  cast_shift i_shift (
    .norm_i  ( norm_q  ),
    .shift_o ( shift_d )
  );

  cast_pipe_reg #(
    .payload_t ( shifted_t )
  ) i_reg_shift (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .flush_i   ( flush_i     ),
    .valid_i   ( norm_valid  ),
    .payload_i ( shift_d     ),
    .ready_o   ( norm_ready  ),
    .ready_i   ( shift_ready ),
    .valid_o   ( shift_valid ),
    .payload_o ( shift_q     )
  );

  // ----------------------------------------------------------------------
  // Stage 3 rounding and flags
  // ----------------------------------------------------------------------
  cast_round i_round (
    .shift_i ( shift_q ),
    .rsp_o   ( rsp_d   )
  );

  cast_pipe_reg #(
    .payload_t ( cast_rsp_t )
  ) i_reg_rsp (
    .clk_i     ( clk_i       ),
    .rst_n_i   ( rst_n_i     ),
    .flush_i   ( flush_i     ),
    .valid_i   ( shift_valid ),
    .payload_i ( rsp_d       ),
    .ready_o   ( shift_ready ),
    .ready_i   ( out_ready_i ),
    .valid_o   ( out_valid_o ),
    .payload_o ( rsp_o       )
  );

  assign busy_o = norm_valid | shift_valid | out_valid_o;  // Anything in flight

endmodule

/* hw/cast_round.sv */
module cast_round (
  input  cast_pkg::shifted_t  shift_i,
  output cast_pkg::cast_rsp_t rsp_o
);
  import cast_pkg::*;

  localparam logic [INT_WIDTH-1:0] INT_MIN_MAG = {1'b1, {(INT_WIDTH-1){1'b0}}};

  logic                 is_f2i;
  logic [1:0]           rs;                 // Round and sticky
  logic                 inexact;
  logic [INT_WIDTH-1:0] pre_round_abs;
  logic                 round_up;
  logic [INT_WIDTH-1:0] rounded_abs;
  // Float path
  logic                 fp_of_after_round;
  logic                 fp_of;
  logic [FP_WIDTH-1:0]  fp_result;
  status_t              fp_status;
  // Integer path
  logic [INT_WIDTH-1:0] int_regular;
  logic                 int_rounded_zero;
  logic                 int_of_after_round;
  logic                 int_special;
  logic [INT_WIDTH-1:0] int_special_res;
  logic [INT_WIDTH-1:0] int_result;
  status_t              int_status;

  assign is_f2i  = (shift_i.op == F2I);
  assign rs      = shift_i.round_sticky;
  assign inexact = |rs;

  // Float magnitude is {exponent, fraction}, a carry bumps the exponent
  assign pre_round_abs = is_f2i ? shift_i.int_val
                                : INT_WIDTH'({shift_i.exp_field, shift_i.fp_mant});

  // ----------------------------------------------------------------------
  // Rounding
  // ----------------------------------------------------------------------
  always_comb begin
    case (shift_i.rnd_mode)
      RNE:     round_up = rs[1] & (rs[0] | pre_round_abs[0]);  // Ties go to even
      RTZ:     round_up = 1'b0;
      RDN:     round_up = inexact & shift_i.sign;              // Toward minus infinity
      RUP:     round_up = inexact & ~shift_i.sign;
      RMM:     round_up = rs[1];                               // Ties away from zero
      default: round_up = 1'b0;
    endcase
  end

  assign rounded_abs = pre_round_abs + INT_WIDTH'(round_up);

  // ----------------------------------------------------------------------
  // Float result
  // ----------------------------------------------------------------------
  assign fp_of_after_round = (rounded_abs[FP_WIDTH-2 -: EXP_BITS] == '1);
  assign fp_of             = shift_i.of_before_round | fp_of_after_round;

  always_comb begin
    fp_status = '0;
    if (shift_i.mant_is_zero) begin
      fp_result = '0;                                         // Integer zero is +0
    end else begin
      fp_result    = {shift_i.sign, rounded_abs[FP_WIDTH-2:0]};
      fp_status.of = fp_of;
      fp_status.nx = inexact | fp_of;
    end
  end

  // ----------------------------------------------------------------------
  // Integer result
  // ----------------------------------------------------------------------
  assign int_regular      = shift_i.sign ? -rounded_abs : rounded_abs;
  assign int_rounded_zero = (rounded_abs == '0);

  // Signed range is exceeded by a carry, except at exactly -2^31
  assign int_of_after_round = ~shift_i.op_mod & rounded_abs[INT_WIDTH-1]
                            & ~(shift_i.sign & (rounded_abs == INT_MIN_MAG));

  assign int_special = shift_i.info.is_nan | shift_i.info.is_inf
                     | shift_i.of_before_round | int_of_after_round
                     | (shift_i.sign & shift_i.op_mod & ~int_rounded_zero);  // Negative to unsigned

  always_comb begin
    // Positive max, all ones when unsigned
    int_special_res = {shift_i.op_mod, {(INT_WIDTH-1){1'b1}}};
    if (shift_i.sign && !shift_i.info.is_nan) begin
      int_special_res = ~int_special_res;                     // Minimum or zero
    end
  end

  always_comb begin
    int_status = '0;
    if (int_special) begin
      int_result    = int_special_res;
      int_status.nv = 1'b1;                                   // NV alone
    end else begin
      int_result    = int_regular;
      int_status.nx = inexact;
    end
  end

  assign rsp_o.result = is_f2i ? int_result : fp_result;
  assign rsp_o.status = is_f2i ? int_status : fp_status;
  assign rsp_o.tag    = shift_i.tag;

endmodule

/* hw/cast_shift.sv */
module cast_shift (
  input  cast_pkg::norm_t    norm_i,
  output cast_pkg::shifted_t shift_o
);
  import cast_pkg::*;

  localparam int unsigned SHIFT_WIDTH = MANT_WIDTH + INT_WIDTH;
  localparam int unsigned FP_RND_BIT  = MANT_WIDTH - 2 - MAN_BITS;  // First bit below fraction
  localparam int unsigned MAX_EXP     = 2**EXP_BITS - 1;            // Inf and NaN exponent

  logic                   is_f2i;
  logic [EXP_WIDTH-1:0]   of_limit;       // Unsigned has one more bit of range
  logic                   exact_int_min;  // -2^31 fits a signed integer
  logic [EXP_WIDTH-1:0]   shamt;
  logic [SHIFT_WIDTH-1:0] shifted;
  logic [EXP_WIDTH-1:0]   biased_exp;

  assign is_f2i   = (norm_i.op == F2I);
  assign of_limit = EXP_WIDTH'(INT_WIDTH - 1) + EXP_WIDTH'(norm_i.op_mod);

  assign exact_int_min = ~norm_i.op_mod & norm_i.sign
                       & (norm_i.exponent == EXP_WIDTH'(INT_WIDTH - 1))
                       & (norm_i.mant == {1'b1, {(MANT_WIDTH-1){1'b0}}});

  // Right shift so the integer part lands in the upper half
  assign shamt   = EXP_WIDTH'(MANT_WIDTH - 1) - norm_i.exponent;
  assign shifted = {norm_i.mant, {INT_WIDTH{1'b0}}} >> shamt;

  assign biased_exp = norm_i.exponent + EXP_WIDTH'(BIAS);

  always_comb begin
    // Pass-through fields
    shift_o.op              = norm_i.op;
    shift_o.op_mod          = norm_i.op_mod;
    shift_o.rnd_mode        = norm_i.rnd_mode;
    shift_o.tag             = norm_i.tag;
    shift_o.sign            = norm_i.sign;
    shift_o.info            = norm_i.info;
    shift_o.mant_is_zero    = norm_i.mant_is_zero;
    // Defaults
    shift_o.exp_field       = '0;
    shift_o.fp_mant         = '0;
    shift_o.int_val         = '0;
    shift_o.round_sticky    = 2'b00;
    shift_o.of_before_round = 1'b0;
    shift_o.uf_before_round = 1'b0;

    if (is_f2i) begin
      // ------------------------------------------------------------------
      // Float to integer placement
      // ------------------------------------------------------------------
      if ($signed(norm_i.exponent) >= $signed(of_limit) && !exact_int_min) begin
        shift_o.of_before_round = 1'b1;           // Also catches inf and NaN
      end else if ($signed(norm_i.exponent) < -1) begin
        shift_o.uf_before_round = 1'b1;           // Below one half
        shift_o.round_sticky    = {1'b0, ~norm_i.mant_is_zero};
      end else begin
        shift_o.int_val      = shifted[SHIFT_WIDTH-1 -: INT_WIDTH];
        shift_o.round_sticky = {shifted[INT_WIDTH-1], |shifted[INT_WIDTH-2:0]};
      end
    end else begin
      // ------------------------------------------------------------------
      // Integer to float placement
      // ------------------------------------------------------------------
      if ($signed(biased_exp) >= $signed(EXP_WIDTH'(MAX_EXP))) begin
        // Largest normal with R and S set, rounding picks inf or max
        shift_o.exp_field       = EXP_BITS'(MAX_EXP - 1);
        shift_o.fp_mant         = '1;
        shift_o.round_sticky    = 2'b11;
        shift_o.of_before_round = 1'b1;
      end else begin
        shift_o.exp_field    = biased_exp[EXP_BITS-1:0];
        shift_o.fp_mant      = norm_i.mant[MANT_WIDTH-2 -: MAN_BITS];  // Drop hidden bit
        shift_o.round_sticky = {norm_i.mant[FP_RND_BIT], |norm_i.mant[FP_RND_BIT-1:0]};
      end
    end
  end

  // Signed value in range keeps the top bit clear except for exactly -2^31
  int_range_a: assert final (!(is_f2i === 1'b1 && norm_i.op_mod === 1'b0 &&
                               shift_o.of_before_round === 1'b0 &&
                               shift_o.uf_before_round === 1'b0 &&
                               shift_o.int_val[INT_WIDTH-1] === 1'b1 &&
                               exact_int_min === 1'b0))
    else $error("cast_shift placed a signed value outside the integer range");

endmodule

/* hw/cast_decode.sv */
module cast_decode (
  input  cast_pkg::cast_req_t req_i,
  output cast_pkg::norm_t     norm_o
);
  import cast_pkg::*;

  localparam int unsigned LZC_WIDTH = $clog2(MANT_WIDTH);
  localparam int unsigned FP_PAD    = MANT_WIDTH - MAN_BITS - 1;  // Zeros below fraction

  logic                  is_i2f;
  logic                  fp_sign;
  logic [EXP_BITS-1:0]   fp_exp;
  logic [MAN_BITS-1:0]   fp_man;
  logic                  fp_normal;
  fp_info_t              info;
  logic                  int_sign;
  logic [INT_WIDTH-1:0]  int_mag;
  logic [MANT_WIDTH-1:0] fp_mant_al;   // Left aligned float mantissa
  logic [MANT_WIDTH-1:0] enc_mant;
  logic [LZC_WIDTH-1:0]  lz_cnt;
  logic [EXP_WIDTH-1:0]  fp_unb_exp;
  logic [EXP_WIDTH-1:0]  int_unb_exp;

  assign is_i2f = (req_i.op == I2F);

  // ----------------------------------------------------------------------
  // Float unpack and classify
  // ----------------------------------------------------------------------
  assign {fp_sign, fp_exp, fp_man} = req_i.operand;

  always_comb begin
    info.is_zero       = (fp_exp == '0) && (fp_man == '0);
    info.is_subnormal  = (fp_exp == '0) && (fp_man != '0);
    info.is_inf        = (fp_exp == '1) && (fp_man == '0);
    info.is_nan        = (fp_exp == '1) && (fp_man != '0);
    info.is_signalling = info.is_nan && !fp_man[MAN_BITS-1];  // Quiet bit clear
  end

  assign fp_normal  = (fp_exp != '0);                          // Hidden bit
  assign fp_mant_al = {fp_normal, fp_man, {FP_PAD{1'b0}}};

  // ----------------------------------------------------------------------
  // Integer magnitude
  // ----------------------------------------------------------------------
  // Only signed inputs can be negative
  assign int_sign = req_i.operand[INT_WIDTH-1] & ~req_i.op_mod;
  assign int_mag  = int_sign ? -req_i.operand : req_i.operand;

  assign enc_mant = is_i2f ? int_mag : fp_mant_al;

  // Leading zero count, highest set bit wins
  always_comb begin
    lz_cnt = '0;
    for (int i = 0; i < MANT_WIDTH; i++) begin
      if (enc_mant[i]) begin
        lz_cnt = LZC_WIDTH'(MANT_WIDTH - 1 - i);
      end
    end
  end

  // Subnormals use exponent 1 and are corrected by the shift
  assign fp_unb_exp  = EXP_WIDTH'(fp_exp) + EXP_WIDTH'(info.is_subnormal)
                     - EXP_WIDTH'(BIAS) - EXP_WIDTH'(lz_cnt);
  assign int_unb_exp = EXP_WIDTH'(MANT_WIDTH - 1) - EXP_WIDTH'(lz_cnt);  // Position of top one

  // ----------------------------------------------------------------------
  // Normalized output
  // ----------------------------------------------------------------------
  always_comb begin
    norm_o.op           = req_i.op;
    norm_o.op_mod       = req_i.op_mod;
    norm_o.rnd_mode     = req_i.rnd_mode;
    norm_o.tag          = req_i.tag;
    norm_o.sign         = is_i2f ? int_sign : fp_sign;
    norm_o.exponent     = is_i2f ? int_unb_exp : fp_unb_exp;
    norm_o.mant         = enc_mant << lz_cnt;  // Top bit now one
    norm_o.mant_is_zero = (enc_mant == '0);    // Integer zero or float zero
    norm_o.info         = is_i2f ? fp_info_t'('0) : info;  // Class only for float sources
  end

endmodule

/* hw/cast_pipe_reg.sv */
module cast_pipe_reg #(
  parameter type payload_t = logic  // Stage payload struct
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  input  payload_t payload_i,
  output logic     ready_o,
  // Downstream side
  input  logic     ready_i,
  output logic     valid_o,
  output payload_t payload_o
);

  logic     valid_q;
  payload_t payload_q;
  logic     load;       // Transfer from upstream this cycle

  // Accept when downstream takes our item or we hold only a bubble
  assign ready_o = ready_i | ~valid_q;
  assign load    = valid_i & ready_o;

  // Valid bit, flush wins over a new item
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;  // Fill or drain
    end
  end

  // Data only moves on a real transfer
  always_ff @(posedge clk_i) begin
    if (load) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;

  // Held item must not change under back-pressure
  hold_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> $stable(payload_o))
    else $error("cast_pipe_reg payload changed while stalled");

endmodule

/* hw/cast_pkg.sv */
package cast_pkg;

  // ----------------------------------------------------------------------
  // Format constants
  // ----------------------------------------------------------------------
  localparam int unsigned FP_WIDTH   = 32;  // binary32 word
  localparam int unsigned EXP_BITS   = 8;
  localparam int unsigned MAN_BITS   = 23;  // stored fraction, hidden bit excluded
  localparam int unsigned BIAS       = 127;
  localparam int unsigned INT_WIDTH  = 32;

  // Internal mantissa holds either the float mantissa with hidden bit or a full integer
  localparam int unsigned MANT_WIDTH = 32;
  // Signed exponent, wide enough for the smallest subnormal (-149)
  localparam int unsigned EXP_WIDTH  = 10;
  localparam int unsigned TAG_WIDTH  = 4;

  // ----------------------------------------------------------------------
  // Enums and flags
  // ----------------------------------------------------------------------
  typedef enum logic {
    I2F = 1'b0,  // Integer to binary32
    F2I = 1'b1   // Binary32 to integer
  } cast_op_e;

  // RISC-V frm encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100
  } round_mode_e;

  // Same bit order as fflags
  typedef struct packed {
    logic nv;  // Invalid
    logic dz;  // Divide by zero, never set here
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // ----------------------------------------------------------------------
  // Stage payloads
  // ----------------------------------------------------------------------
  typedef struct packed {
    cast_op_e               op;
    logic                   op_mod;   // Unsigned integer when set
    round_mode_e            rnd_mode;
    logic [INT_WIDTH-1:0]   operand;  // Integer or binary32 bits
    logic [TAG_WIDTH-1:0]   tag;
  } cast_req_t;

  typedef struct packed {
    cast_op_e               op;
    logic                   op_mod;
    round_mode_e            rnd_mode;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   sign;
    logic [EXP_WIDTH-1:0]   exponent;      // Unbiased, two's complement
    logic [MANT_WIDTH-1:0]  mant;          // MSB set unless zero
    logic                   mant_is_zero;
    fp_info_t               info;
  } norm_t;

  typedef struct packed {
    cast_op_e               op;
    logic                   op_mod;
    round_mode_e            rnd_mode;
    logic [TAG_WIDTH-1:0]   tag;
    logic                   sign;
    logic [EXP_BITS-1:0]    exp_field;     // Biased float exponent
    logic [MAN_BITS-1:0]    fp_mant;       // Float fraction before rounding
    logic [INT_WIDTH-1:0]   int_val;       // Integer magnitude before rounding
    logic [1:0]             round_sticky;  // {round, sticky}
    logic                   of_before_round;
    logic                   uf_before_round;
    fp_info_t               info;
    logic                   mant_is_zero;
  } shifted_t;

  typedef struct packed {
    logic [FP_WIDTH-1:0]    result;
    status_t                status;
    logic [TAG_WIDTH-1:0]   tag;
  } cast_rsp_t;

endpackage
